//--- source/rover_pkg.sv
// Shared types, seven-segment glyphs and timing defaults for the rover drive controller
// Imported by every RTL block of the rover

`default_nettype none

package rover_pkg;

    // --------------------------------------------------
    // Timing defaults for a 100 MHz board clock
    // --------------------------------------------------
    localparam int DEF_CARRIER_CYCLES = 250000;  // 400 Hz PWM carrier
    localparam int DEF_REFRESH_CYCLES = 416666;  // Per digit, about 60 Hz full scan

    // Inductive line sensors, active low, 1 means no line under the sensor
    typedef struct packed {
        logic left;
        logic middle;
        logic right;
    } line_sense_t;

    typedef enum logic [1:0] {
        STEER_STOP  = 2'd0,
        STEER_FWD   = 2'd1,
        STEER_LEFT  = 2'd2,
        STEER_RIGHT = 2'd3
    } steer_mode_t;

    typedef struct packed {
        steer_mode_t mode;
        logic [2:0]  duty_level;  // Quarters of full scale, 0 to 4
    } drive_cmd_t;

    // One motor on the H-bridge
    typedef struct packed {
        logic in1;
        logic in2;
        logic pwm;  // Bridge enable, carries the duty cycle
    } motor_pins_t;

    typedef struct packed {
        motor_pins_t motor_a;  // Left side
        motor_pins_t motor_b;  // Right side
    } bridge_t;

    // --------------------------------------------------
    // Seven-segment glyphs, bit order a..g, active low
    // --------------------------------------------------
    typedef logic [6:0] glyph_t;

    localparam glyph_t GLYPH_F      = 7'b0111000;
    localparam glyph_t GLYPH_L      = 7'b1110001;
    localparam glyph_t GLYPH_R      = 7'b1111010;  // Lower case r
    localparam glyph_t GLYPH_DASH   = 7'b1111110;  // Segment g only
    localparam glyph_t GLYPH_I      = 7'b1111001;  // Left column, e and f
    localparam glyph_t GLYPH_H      = 7'b1001000;
    localparam glyph_t GLYPH_BLANK  = 7'b1111111;
    localparam glyph_t GLYPH_DIGIT0 = 7'b0000001;
    localparam glyph_t GLYPH_DIGIT1 = 7'b1001111;
    localparam glyph_t GLYPH_DIGIT2 = 7'b0010010;
    localparam glyph_t GLYPH_DIGIT3 = 7'b0000110;
    localparam glyph_t GLYPH_DIGIT4 = 7'b1001100;
    localparam glyph_t GLYPH_DIGIT5 = 7'b0100100;
    localparam glyph_t GLYPH_DIGIT6 = 7'b0100000;
    localparam glyph_t GLYPH_DIGIT7 = 7'b0001111;
    localparam glyph_t GLYPH_DIGIT8 = 7'b0000000;
    localparam glyph_t GLYPH_DIGIT9 = 7'b0000100;

    // Multiplexed display pins, all active low
    typedef struct packed {
        logic [3:0] anode;     // One low bit selects the digit
        glyph_t     segments;  // a..g
        logic       dp;
    } display_t;

endpackage

`default_nettype wire

//--- source/steer_decode.sv
// Steering decode: sensor levels and duty switches become one registered drive command
// Output changes one clock after the inputs

`timescale 1ns/100ps
`default_nettype none

module steer_decode (
    input  logic                   clk,
    input  logic                   rst_in,
    input  rover_pkg::line_sense_t line_sense,
    input  logic [3:0]             duty_sw,
    output rover_pkg::drive_cmd_t  drive_cmd
);
    import rover_pkg::*;

    steer_mode_t mode_next;
    logic [2:0]  level_next;

    // --------------------------------------------------
    // Steering priority, sensors active low
    // --------------------------------------------------
    always_comb begin
        if (line_sense.left && line_sense.middle && line_sense.right) begin
            mode_next = STEER_STOP;  // Line lost on all three
        end else if (!line_sense.right) begin
            mode_next = STEER_RIGHT;  // Right wins over left
        end else if (!line_sense.left) begin
            mode_next = STEER_LEFT;
        end else begin
            mode_next = STEER_FWD;  // Middle only
        end
    end

    // Lowest numbered switch sets the speed
    always_comb begin
        if (duty_sw[0]) begin
            level_next = 3'd4;  // 100 %
        end else if (duty_sw[1]) begin
            level_next = 3'd3;  // 75 %
        end else if (duty_sw[2]) begin
            level_next = 3'd2;  // 50 %
        end else if (duty_sw[3]) begin
            level_next = 3'd1;  // 25 %
        end else begin
            level_next = 3'd0;  // No switch, motors idle
        end
    end

    // --------------------------------------------------
    // Command register
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst_in) begin
            drive_cmd.mode       <= STEER_STOP;
            drive_cmd.duty_level <= 3'd0;
        end else begin
            drive_cmd.mode       <= mode_next;
            drive_cmd.duty_level <= level_next;
        end
    end

endmodule

`default_nettype wire

//--- source/motor_drive.sv
// Motor drive: PWM carrier, bridge direction pins and the latched over-current cut-off
// Pins are registered one clock after drive_cmd; fault kills pwm on the edge it sets

`timescale 1ns/100ps
`default_nettype none

module motor_drive #(
    parameter int CARRIER_CYCLES = rover_pkg::DEF_CARRIER_CYCLES
) (
    input  logic                  clk,
    input  logic                  rst_in,
    input  rover_pkg::drive_cmd_t drive_cmd,
    input  logic                  over_current_a,
    input  logic                  over_current_b,
    input  logic                  fault_clear,
    output rover_pkg::bridge_t    bridge,
    output logic                  fault
);
    import rover_pkg::*;

    // Wide enough to hold the full-scale threshold
    localparam int CNT_W = $clog2(CARRIER_CYCLES + 1);
    localparam logic [CNT_W-1:0] CARRIER_LAST = CNT_W'(CARRIER_CYCLES - 1);
    localparam logic [CNT_W-1:0] THR_25  = CNT_W'(CARRIER_CYCLES / 4);
    localparam logic [CNT_W-1:0] THR_50  = CNT_W'(CARRIER_CYCLES / 2);
    localparam logic [CNT_W-1:0] THR_75  = CNT_W'((CARRIER_CYCLES / 4) * 3);
    localparam logic [CNT_W-1:0] THR_100 = CNT_W'(CARRIER_CYCLES);

    // Direction pairs {in1, in2}; B is wired mirrored to A
    localparam logic [1:0] A_FWD   = 2'b01;
    localparam logic [1:0] A_REV   = 2'b10;
    localparam logic [1:0] B_FWD   = 2'b10;
    localparam logic [1:0] B_REV   = 2'b01;
    localparam logic [1:0] DIR_OFF = 2'b00;

    logic [CNT_W-1:0] carrier_cnt;
    logic [CNT_W-1:0] threshold;
    logic [1:0]       dir_a;
    logic [1:0]       dir_b;
    logic             fault_next;
    logic             pwm_next;

    // --------------------------------------------------
    // Carrier counter, 0 to CARRIER_CYCLES-1
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst_in) begin
            carrier_cnt <= '0;
        end else if (carrier_cnt == CARRIER_LAST) begin
            carrier_cnt <= '0;  // Wrap
        end else begin
            carrier_cnt <= carrier_cnt + 1'b1;
        end
    end

    // Compare threshold in quarters of a period
    always_comb begin
        case (drive_cmd.duty_level)
            3'd1:    threshold = THR_25;
            3'd2:    threshold = THR_50;
            3'd3:    threshold = THR_75;
            3'd4:    threshold = THR_100;
            default: threshold = '0;  // Level 0, never high
        endcase
    end

    // --------------------------------------------------
    // Over-current latch
    // --------------------------------------------------
    // Either trip sets it; clear only counts once both inputs are quiet
    assign fault_next = over_current_a | over_current_b | (fault & ~fault_clear);

    always_ff @(posedge clk) begin
        if (rst_in) begin
            fault <= 1'b0;
        end else begin
            fault <= fault_next;
        end
    end

    // Same next-state as the latch, so pwm drops on the setting edge
    assign pwm_next = (carrier_cnt < threshold) && (drive_cmd.mode != STEER_STOP) &&
                      !fault_next;

    // --------------------------------------------------
    // Direction pins per steering mode
    // --------------------------------------------------
    always_comb begin
        case (drive_cmd.mode)
            STEER_FWD: begin
                dir_a = A_FWD;
                dir_b = B_FWD;
            end
            STEER_LEFT: begin  // Pivot, A backs up
                dir_a = A_REV;
                dir_b = B_FWD;
            end
            STEER_RIGHT: begin  // Pivot, B backs up
                dir_a = A_FWD;
                dir_b = B_REV;
            end
            default: begin  // STOP, bridge coasts
                dir_a = DIR_OFF;
                dir_b = DIR_OFF;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_in) begin
            bridge <= '0;
        end else begin
            bridge.motor_a <= {dir_a, pwm_next};
            bridge.motor_b <= {dir_b, pwm_next};  // Both motors share one duty
        end
    end

endmodule

`default_nettype wire

//--- source/status_display.sv
// Status display: scans four seven-segment digits with mode and duty, or IH-- on a fault
// Anode and segments are registered together, one digit per REFRESH_CYCLES clocks

`timescale 1ns/100ps
`default_nettype none

module status_display #(
    parameter int REFRESH_CYCLES = rover_pkg::DEF_REFRESH_CYCLES
) (
    input  logic                  clk,
    input  logic                  rst_in,
    input  rover_pkg::drive_cmd_t drive_cmd,
    input  logic                  fault,
    output rover_pkg::display_t   display
);
    import rover_pkg::*;

    localparam int REF_W = $clog2(REFRESH_CYCLES + 1);
    localparam logic [REF_W-1:0] REFRESH_LAST = REF_W'(REFRESH_CYCLES - 1);

    logic [REF_W-1:0] refresh_cnt;
    logic [1:0]       digit_idx;  // Digit 0 to 3
    logic [3:0]       anode_next;
    glyph_t           mode_glyph;
    glyph_t           tens_glyph;
    glyph_t           units_glyph;
    glyph_t           digit_glyph;

    // --------------------------------------------------
    // Refresh timer and digit scan
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst_in) begin
            refresh_cnt <= '0;
            digit_idx   <= 2'd0;
        end else if (refresh_cnt == REFRESH_LAST) begin
            refresh_cnt <= '0;
            digit_idx   <= digit_idx + 2'd1;  // 3 wraps back to 0
        end else begin
            refresh_cnt <= refresh_cnt + 1'b1;
        end
    end

    // One anode low at a time
    assign anode_next = ~(4'b0001 << digit_idx);

    // --------------------------------------------------
    // Glyph selection
    // --------------------------------------------------
    always_comb begin
        case (drive_cmd.mode)
            STEER_FWD:   mode_glyph = GLYPH_F;
            STEER_LEFT:  mode_glyph = GLYPH_L;
            STEER_RIGHT: mode_glyph = GLYPH_R;
            default:     mode_glyph = GLYPH_DASH;  // Stopped
        endcase
    end

    // Duty percent on digits 2 and 3
    always_comb begin
        case (drive_cmd.duty_level)
            3'd4: begin  // Full scale reads 10, the last 0 has no digit left
                tens_glyph  = GLYPH_DIGIT1;
                units_glyph = GLYPH_DIGIT0;
            end
            3'd3: begin
                tens_glyph  = GLYPH_DIGIT7;
                units_glyph = GLYPH_DIGIT5;
            end
            3'd2: begin
                tens_glyph  = GLYPH_DIGIT5;
                units_glyph = GLYPH_DIGIT0;
            end
            3'd1: begin
                tens_glyph  = GLYPH_DIGIT2;
                units_glyph = GLYPH_DIGIT5;
            end
            default: begin  // Zero, leading blank
                tens_glyph  = GLYPH_BLANK;
                units_glyph = GLYPH_DIGIT0;
            end
        endcase
    end

    // Fault text overrides everything
    always_comb begin
        case (digit_idx)
            2'd0:    digit_glyph = fault ? GLYPH_I : mode_glyph;
            2'd1:    digit_glyph = fault ? GLYPH_H : GLYPH_BLANK;  // Gap after the mode
            2'd2:    digit_glyph = fault ? GLYPH_DASH : tens_glyph;
            default: digit_glyph = fault ? GLYPH_DASH : units_glyph;
        endcase
    end

    // --------------------------------------------------
    // Output register, anode and segments move together
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst_in) begin
            display.anode    <= 4'b1110;  // Digit 0
            display.segments <= GLYPH_BLANK;
            display.dp       <= 1'b1;  // Off
        end else begin
            display.anode    <= anode_next;
            display.segments <= digit_glyph;
            display.dp       <= 1'b1;  // Decimal point unused
        end
    end

endmodule

`default_nettype wire

//--- source/rover_top.sv
// Rover drive controller top level: steering decode, motor drive and status display
// Timing parameters are set here and passed to the drive and display blocks

`timescale 1ns/100ps
`default_nettype none

module rover_top #(
    parameter int CARRIER_CYCLES = rover_pkg::DEF_CARRIER_CYCLES,
    parameter int REFRESH_CYCLES = rover_pkg::DEF_REFRESH_CYCLES
) (
    input  logic                   clk,
    input  logic                   rst_in,
    input  rover_pkg::line_sense_t line_sense,
    input  logic [3:0]             duty_sw,
    input  logic                   over_current_a,
    input  logic                   over_current_b,
    input  logic                   fault_clear,
    output rover_pkg::bridge_t     bridge,
    output rover_pkg::display_t    display
);
    import rover_pkg::*;

    drive_cmd_t drive_cmd;  // Decode to drive and display
    logic       fault;      // Latched over-current

    // --------------------------------------------------
    // Decode, execute, result
    // --------------------------------------------------
    steer_decode u_decode (
        .clk        (clk),
        .rst_in     (rst_in),
        .line_sense (line_sense),
        .duty_sw    (duty_sw),
        .drive_cmd  (drive_cmd)
    );

    motor_drive #(
        .CARRIER_CYCLES (CARRIER_CYCLES)
    ) u_drive (
        .clk            (clk),
        .rst_in         (rst_in),
        .drive_cmd      (drive_cmd),
        .over_current_a (over_current_a),
        .over_current_b (over_current_b),
        .fault_clear    (fault_clear),
        .bridge         (bridge),
        .fault          (fault)
    );

    status_display #(
        .REFRESH_CYCLES (REFRESH_CYCLES)
    ) u_display (
        .clk       (clk),
        .rst_in    (rst_in),
        .drive_cmd (drive_cmd),
        .fault     (fault),
        .display   (display)
    );

endmodule

`default_nettype wire

//--- dv/tb_clock.sv
// Free-running testbench clock, 40 ns period by default
// Instantiated once by the testbench top

`timescale 1ns/100ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS = 40
) (
    output logic clk
);
    initial begin
        clk = 1'b0;  // Known level before the first edge
    end

    always begin
        #(PERIOD_NS / 2);  // Half period
        clk = ~clk;
    end

endmodule

`default_nettype wire

//--- dv/rover_chk.sv
// Concurrent assertions on the H-bridge pins, bound into the rover top level
// Watches pwm against the fault latch and the direction pairs

`timescale 1ns/100ps
`default_nettype none

module rover_chk (
    input logic               clk,
    input logic               rst_in,
    input rover_pkg::bridge_t bridge,
    input logic               fault
);

    // --------------------------------------------------
    // Over-current cut-off
    // --------------------------------------------------
    fault_kills_pwm: assert property (@(posedge clk) disable iff (rst_in)
        fault |-> (!bridge.motor_a.pwm && !bridge.motor_b.pwm))
        else $error("pwm enable high while the over-current fault is latched");

    // --------------------------------------------------
    // Direction pairs, no shoot-through
    // --------------------------------------------------
    a_no_shoot: assert property (@(posedge clk) disable iff (rst_in)
        !(bridge.motor_a.in1 && bridge.motor_a.in2))
        else $error("motor A in1 and in2 both high");

    b_no_shoot: assert property (@(posedge clk) disable iff (rst_in)
        !(bridge.motor_b.in1 && bridge.motor_b.in2))
        else $error("motor B in1 and in2 both high");

    // Coasting motor has no enable
    a_coast_off: assert property (@(posedge clk) disable iff (rst_in)
        (!bridge.motor_a.in1 && !bridge.motor_a.in2) |-> !bridge.motor_a.pwm)
        else $error("motor A pwm high with both direction pins low");

    b_coast_off: assert property (@(posedge clk) disable iff (rst_in)
        (!bridge.motor_b.in1 && !bridge.motor_b.in2) |-> !bridge.motor_b.pwm)
        else $error("motor B pwm high with both direction pins low");

endmodule

// Internal fault net is reached from the rover_top scope
bind rover_top rover_chk u_chk (
    .clk    (clk),
    .rst_in (rst_in),
    .bridge (bridge),
    .fault  (fault)
);

`default_nettype wire

//--- dv/rover_tb.sv
// Directed testbench for the rover drive controller: steering, PWM duty, fault latch, display
// Short carrier and refresh periods keep the run fast

`timescale 1ns/100ps
`default_nettype none

module rover_tb;
    import rover_pkg::*;

    localparam int CARRIER    = 40;
    localparam int REFRESH    = 8;
    localparam int SETTLE     = 4;    // Sensor to bridge, with margin
    localparam int WINDOW     = 160;  // Four whole carrier periods
    localparam int SCAN_LIMIT = 4 * REFRESH + 8;

    logic        clk;
    logic        rst_in;
    line_sense_t line_sense;
    logic [3:0]  duty_sw;
    logic        over_current_a;
    logic        over_current_b;
    logic        fault_clear;
    bridge_t     bridge;
    display_t    display;
    int          seed;
    bit          failed;

    tb_clock #(.PERIOD_NS(40)) u_clock (.clk(clk));

    rover_top #(
        .CARRIER_CYCLES (CARRIER),
        .REFRESH_CYCLES (REFRESH)
    ) UUT (
        .clk            (clk),
        .rst_in         (rst_in),
        .line_sense     (line_sense),
        .duty_sw        (duty_sw),
        .over_current_a (over_current_a),
        .over_current_b (over_current_b),
        .fault_clear    (fault_clear),
        .bridge         (bridge),
        .display        (display)
    );

    // --------------------------------------------------
    // Expected behavior
    // --------------------------------------------------
    function automatic steer_mode_t mode_for(input line_sense_t s);
        return (s.left && s.middle && s.right) ? STEER_STOP :
               !s.right ? STEER_RIGHT : !s.left ? STEER_LEFT : STEER_FWD;
    endfunction

    function automatic int level_for(input logic [3:0] sw);
        return sw[0] ? 4 : sw[1] ? 3 : sw[2] ? 2 : sw[3] ? 1 : 0;
    endfunction

    // {A in1, A in2, B in1, B in2}
    function automatic logic [3:0] dir_pins_for(input steer_mode_t mode);
        case (mode)
            STEER_FWD:   return 4'b0110;
            STEER_LEFT:  return 4'b1010;  // A reverse
            STEER_RIGHT: return 4'b0101;  // B reverse
            default:     return 4'b0000;
        endcase
    endfunction

    function automatic glyph_t glyph_for(input steer_mode_t mode, input int level,
                                         input bit faulted, input int idx);
        glyph_t fault_text [4] = '{GLYPH_I, GLYPH_H, GLYPH_DASH, GLYPH_DASH};
        glyph_t tens [5] = '{GLYPH_BLANK, GLYPH_DIGIT2, GLYPH_DIGIT5, GLYPH_DIGIT7, GLYPH_DIGIT1};
        glyph_t units [5] = '{GLYPH_DIGIT0, GLYPH_DIGIT5, GLYPH_DIGIT0, GLYPH_DIGIT5,
                              GLYPH_DIGIT0};
        if (faulted) begin
            return fault_text[idx];
        end
        case (idx)
            0:       return (mode == STEER_FWD) ? GLYPH_F : (mode == STEER_LEFT) ? GLYPH_L :
                            (mode == STEER_RIGHT) ? GLYPH_R : GLYPH_DASH;
            1:       return GLYPH_BLANK;  // Gap after the mode letter
            2:       return tens[level];
            default: return units[level];
        endcase
    endfunction

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------
    task automatic next_cycle();
        @(posedge clk);
        #5;  // Drive and sample clear of the edge
    endtask

    task automatic stop_with_failure(input string reason);
        failed = 1'b1;
        $display("%s", reason);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            stop_with_failure($sformatf("error: %s is 0x%0h, expected 0x%0h",
                                        name, actual, expected));
        end
    endtask

    task automatic apply_inputs(input line_sense_t s, input logic [3:0] sw);
        line_sense = s;
        duty_sw    = sw;
        repeat (SETTLE) next_cycle();
    endtask

    task automatic pulse_clear();
        fault_clear = 1'b1;
        next_cycle();
        fault_clear = 1'b0;
    endtask

    // Counts enable-high cycles on both motors over a fixed window
    task automatic expect_pwm_count(input int cycles, input int expected, input string tag);
        int high_a;
        int high_b;
        high_a = 0;
        high_b = 0;
        repeat (cycles) begin
            next_cycle();
            high_a += bridge.motor_a.pwm;
            high_b += bridge.motor_b.pwm;
        end
        check_value({"bridge.motor_a.pwm high count ", tag}, high_a, expected);
        check_value({"bridge.motor_b.pwm high count ", tag}, high_b, expected);
    endtask

    // Steps until all four anodes were seen, checking every digit shown
    task automatic scan_display(input steer_mode_t mode, input int level, input bit faulted);
        logic [3:0] seen;
        int         guard;
        int         idx;
        seen  = 4'b0000;
        guard = 0;
        while (seen != 4'b1111 && guard < SCAN_LIMIT) begin
            next_cycle();
            guard++;
            case (display.anode)
                4'b1110: idx = 0;
                4'b1101: idx = 1;
                4'b1011: idx = 2;
                4'b0111: idx = 3;
                default: stop_with_failure("Display anode does not select exactly one digit");
            endcase
            check_value($sformatf("display.segments digit %0d", idx), display.segments,
                        glyph_for(mode, level, faulted, idx));
            check_value("display.dp", display.dp, 1'b1);
            seen[idx] = 1'b1;
        end
        if (seen != 4'b1111) begin
            stop_with_failure("Display scan timed out before all four digits were shown");
        end
    endtask

    // --------------------------------------------------
    // Directed tests
    // --------------------------------------------------
    task automatic test_reset();
        rst_in = 1'b1;
        repeat (10) next_cycle();
        check_value("bridge in reset", bridge, '0);
        check_value("display.anode in reset", display.anode, 4'b1110);
        rst_in = 1'b0;
        next_cycle();
        check_value("bridge after reset", bridge, '0);
        check_value("display.anode after reset", display.anode, 4'b1110);
    endtask

    task automatic test_steering();
        line_sense_t pat;
        for (int p = 0; p < 8; p++) begin
            pat = p[2:0];
            apply_inputs(pat, 4'b0001);
            check_value($sformatf("bridge direction pins, line_sense %b", pat),
                        {bridge.motor_a.in1, bridge.motor_a.in2,
                         bridge.motor_b.in1, bridge.motor_b.in2},
                        dir_pins_for(mode_for(pat)));
            if (mode_for(pat) == STEER_STOP) begin
                check_value("bridge pwm bits in STOP",
                            {bridge.motor_a.pwm, bridge.motor_b.pwm}, 2'b00);
            end
        end
    endtask

    task automatic test_duty();
        logic [3:0] sw_list [5] = '{4'b0000, 4'b0001, 4'b0010, 4'b0100, 4'b1000};
        logic [3:0] sw;
        foreach (sw_list[k]) begin
            apply_inputs(3'b101, sw_list[k]);  // Middle only, FWD
            expect_pwm_count(WINDOW, WINDOW / 4 * level_for(sw_list[k]), "FWD");
        end
        repeat (4) begin
            sw = 4'($random(seed));  // Mixed switch sets, lowest bit wins
            apply_inputs(3'b101, sw);
            expect_pwm_count(WINDOW, WINDOW / 4 * level_for(sw), "FWD mixed switches");
        end
        apply_inputs(3'b111, 4'b0001);  // Line lost
        expect_pwm_count(WINDOW, 0, "STOP");
    endtask

    task automatic test_over_current();
        apply_inputs(3'b101, 4'b0100);  // FWD at 50 %
        over_current_b = 1'b1;
        next_cycle();
        over_current_b = 1'b0;
        check_value("bridge pwm bits on trip", {bridge.motor_a.pwm, bridge.motor_b.pwm}, 2'b00);
        expect_pwm_count(CARRIER, 0, "after trip");
        pulse_clear();
        expect_pwm_count(WINDOW, WINDOW / 2, "after clear");
        over_current_a = 1'b1;
        next_cycle();
        fault_clear = 1'b1;  // Clear held through the trip has no effect
        expect_pwm_count(CARRIER, 0, "clear during trip");
        fault_clear    = 1'b0;
        over_current_a = 1'b0;
        expect_pwm_count(CARRIER, 0, "latched after trip");
        pulse_clear();
        expect_pwm_count(WINDOW, WINDOW / 2, "after second clear");
    endtask

    task automatic test_display();
        line_sense_t sense_list [5] = '{3'b101, 3'b011, 3'b110, 3'b111, 3'b100};
        logic [3:0]  sw_list [5]    = '{4'b0001, 4'b0010, 4'b1000, 4'b0100, 4'b0000};
        foreach (sense_list[k]) begin
            apply_inputs(sense_list[k], sw_list[k]);
            scan_display(mode_for(sense_list[k]), level_for(sw_list[k]), 1'b0);
        end
        apply_inputs(3'b101, 4'b0010);
        over_current_a = 1'b1;
        next_cycle();
        over_current_a = 1'b0;
        repeat (SETTLE) next_cycle();
        scan_display(STEER_FWD, 3, 1'b1);  // IH--
        pulse_clear();
        repeat (SETTLE) next_cycle();
        scan_display(STEER_FWD, 3, 1'b0);
    endtask

    initial begin
        seed           = 39458;
        failed         = 1'b0;
        rst_in         = 1'b1;
        line_sense     = 3'b111;  // No line
        duty_sw        = 4'b0000;
        over_current_a = 1'b0;
        over_current_b = 1'b0;
        fault_clear    = 1'b0;
        test_reset();
        test_steering();
        test_duty();
        test_over_current();
        test_display();
        if (!failed) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            stop_with_failure("A check failed earlier in the run");
        end
    end

endmodule

`default_nettype wire

//--- sim.f
source/rover_pkg.sv
source/steer_decode.sv
source/motor_drive.sv
source/status_display.sv
source/rover_top.sv
dv/tb_clock.sv
dv/rover_chk.sv
dv/rover_tb.sv

//--- Bender.yml
package:
  name: rover_drive

sources:
  - source/rover_pkg.sv
  - source/steer_decode.sv
  - source/motor_drive.sv
  - source/status_display.sv
  - source/rover_top.sv
  - target: test
    files:
      - dv/tb_clock.sv
      - dv/rover_chk.sv
      - dv/rover_tb.sv
